//--- src.f
+incdir+src
src/io_bus_pkg.sv
src/io_map_pkg.sv
src/io_bus_if.sv
src/io_bridge.sv
src/io_dev_decode.sv
src/io_scratch_regs.sv
src/io_byte_mailbox.sv
src/io_subsystem_top.sv
testbench/tb_io_subsystem.sv

//--- src/io_bridge.sv
// I/O bridge
// takes requests from two CPU-side ports, keeps only those that fall in
// the I/O window and forwards them one at a time onto the registered
// device bus; the ack and read data go back to the port that owns the
// transfer, with the upper address forced to the I/O base
`timescale 1ns/1ns
`default_nettype none

`include "io_cfg.svh"

module io_bridge
	import io_bus_pkg::*;
(
	input  wire logic     clk_i,
	input  wire logic     rst_i,

	input  wire logic     s1_cyc_i,
	input  wire logic     s1_stb_i,
	input  wire logic     s1_we_i,
	input  wire io_sel_t  s1_sel_i,
	input  wire io_adr_t  s1_adr_i,
	input  wire io_data_u s1_dat_i,
	output logic          s1_ack_o,
	output io_data_u      s1_dat_o,

	input  wire logic     s2_cyc_i,
	input  wire logic     s2_stb_i,
	input  wire logic     s2_we_i,
	input  wire io_sel_t  s2_sel_i,
	input  wire io_adr_t  s2_adr_i,
	input  wire io_data_u s2_dat_i,
	output logic          s2_ack_o,
	output io_data_u      s2_dat_o,

	io_bus_if.master      bus_m
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_ACK,
		ST_WAIT_NACK
	} state_e;

	state_e     state;
	// owner of the running transfer, low for port 1 and high for port 2
	logic       owner;
	// internal acknowledge, set one edge after the device ack is seen
	logic       s_ack;

	logic       s1_hit;
	logic       s2_hit;
	logic       own_cyc;
	logic       own_stb;
	logic       req_we;
	io_sel_t    req_sel;
	io_adr_t    req_adr;
	io_data_u   req_dat;
	logic [2:0] req_lane;

	// lowest enabled lane, so a single byte always lands on dat8
	function automatic logic [2:0] low_lane(input io_sel_t sel);
		logic [2:0] lane;
		lane = 3'd0;
		for (int i = $bits(io_sel_t) - 1; i >= 0; i--) begin
			if (sel[i])
				lane = 3'(i);
		end
		return lane;
	endfunction

	// ========================================================
	// request filter and arbitration
	// ========================================================

	// only requests inside the I/O window are ever forwarded
	assign s1_hit = s1_cyc_i & s1_stb_i & (s1_adr_i[`IO_ADR_W-1 -: 12] == `IO_BASE);
	assign s2_hit = s2_cyc_i & s2_stb_i & (s2_adr_i[`IO_ADR_W-1 -: 12] == `IO_BASE);

	// port 1 has priority, a losing port keeps its request held
	assign req_we   = s1_hit ? s1_we_i  : s2_we_i;
	assign req_sel  = s1_hit ? s1_sel_i : s2_sel_i;
	assign req_adr  = s1_hit ? s1_adr_i : s2_adr_i;
	assign req_dat  = s1_hit ? s1_dat_i : s2_dat_i;
	assign req_lane = low_lane(req_sel);

	assign own_cyc = owner ? s2_cyc_i : s1_cyc_i;
	assign own_stb = owner ? s2_stb_i : s1_stb_i;

	// ========================================================
	// transfer state machine
	// ========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= ST_IDLE;
			owner     <= 1'b0;
			s_ack     <= 1'b0;
			bus_m.cyc <= 1'b0;
			bus_m.stb <= 1'b0;
			bus_m.we  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// a trailing device ack must clear before a new sample
					if (!bus_m.ack && (s1_hit || s2_hit)) begin
						owner    <= ~s1_hit;
						bus_m.we <= req_we;
						state    <= ST_WAIT_ACK;
					end
				end
				ST_WAIT_ACK: begin
					if (!own_cyc) begin
						// requester gave up before the device answered
						bus_m.cyc <= 1'b0;
						bus_m.stb <= 1'b0;
						bus_m.we  <= 1'b0;
						state     <= ST_IDLE;
					end else if (bus_m.ack) begin
						s_ack <= 1'b1;
						state <= ST_WAIT_NACK;
					end else begin
						// cycle opens one edge after the sample
						bus_m.cyc <= 1'b1;
						bus_m.stb <= 1'b1;
					end
				end
				ST_WAIT_NACK: begin
					// a slow requester keeps the bus here as long as it likes
					if (!own_stb) begin
						bus_m.cyc <= 1'b0;
						bus_m.stb <= 1'b0;
						bus_m.we  <= 1'b0;
						s_ack     <= 1'b0;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request payload is captured together with the sample in idle
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE && !bus_m.ack && (s1_hit || s2_hit)) begin
			bus_m.sel   <= req_sel;
			bus_m.adr   <= {`IO_BASE, req_adr[19:3], 3'b000};
			bus_m.dat_w <= req_dat;
			bus_m.adr8  <= {`IO_BASE, req_adr[19:3], req_lane};
			bus_m.dat8  <= req_dat.b[req_lane];
		end
	end

	// ========================================================
	// port acknowledge and read data return
	// ========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			s1_ack_o <= 1'b0;
			s2_ack_o <= 1'b0;
		end else begin
			s1_ack_o <= s_ack & s1_stb_i & ~owner;
			s2_ack_o <= s_ack & s2_stb_i & owner;
		end
	end

	// device keeps driving while stb is high, so the word is still valid
	always_ff @(posedge clk_i) begin
		if (s_ack && s1_stb_i && !owner)
			s1_dat_o <= bus_m.dat_r;
		if (s_ack && s2_stb_i && owner)
			s2_dat_o <= bus_m.dat_r;
	end

endmodule

`default_nettype wire

//--- src/io_bus_if.sv
// device bus between the I/O bridge and its devices
// classic cyc/stb/ack handshake plus the steered byte lane
`timescale 1ns/1ns
`default_nettype none

interface io_bus_if import io_bus_pkg::*; ();

	// request side, all registered in the bridge
	logic     cyc;
	logic     stb;
	logic     we;
	io_sel_t  sel;
	io_adr_t  adr;
	io_data_u dat_w;
	// byte address of the lowest enabled lane and the byte on it
	io_adr_t  adr8;
	logic [7:0] dat8;

	// response side, combined in the decoder
	logic     ack;
	io_data_u dat_r;

	modport master (
		output cyc, stb, we, sel, adr, dat_w, adr8, dat8,
		input  ack, dat_r
	);

	modport decode (
		input  cyc, stb, we, adr,
		output ack, dat_r
	);

	// devices only look at the request, they answer on their own ports
	modport dev (
		input cyc, stb, we, sel, adr, dat_w, adr8, dat8
	);

endinterface

`default_nettype wire

//--- src/io_bus_pkg.sv
// I/O bus data types
// address, byte enables and the 64-bit data word with its two views
`default_nettype none

`include "io_cfg.svh"

package io_bus_pkg;

	// full byte address as seen on either side of the bridge
	typedef logic [`IO_ADR_W-1:0] io_adr_t;

	// one enable per byte lane of the data word
	typedef logic [`IO_DAT_W/8-1:0] io_sel_t;

	// a data word is decoded lane by lane for steering and merging,
	// and as two 32-bit halves when building replicated read data
	typedef union packed {
		logic [`IO_DAT_W/8-1:0][7:0] b;
		logic [1:0][`IO_DAT_W/2-1:0] h;
	} io_data_u;

endpackage

`default_nettype wire

//--- src/io_byte_mailbox.sv
// byte mailbox
// sixteen bytes written through the steered byte lane of the bridge;
// a read returns the addressed byte in every lane
`timescale 1ns/1ns
`default_nettype none

`include "io_cfg.svh"

module io_byte_mailbox
	import io_bus_pkg::*;
	import io_map_pkg::*;
(
	input  wire logic clk_i,
	input  wire logic rst_i,
	io_bus_if.dev     bus_s,
	input  wire logic sel_i,
	output logic      ack_o,
	output io_data_u  dat_o
);

	logic [7:0]   mem [16];
	io_mbox_idx_t idx;
	logic [$bits(io_data_u)/2-1:0] half;

	// byte index comes from the steered byte address
	assign idx = io_mbox_idx_t'(bus_s.adr8[`IO_MBX_AW-1:0]);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			for (int i = 0; i < 16; i++)
				mem[i] <= 8'h00;
		end else begin
			ack_o <= sel_i & bus_s.stb;
			if (sel_i && bus_s.stb && bus_s.we)
				mem[idx] <= bus_s.dat8;
		end
	end

	// one half holds four copies, both halves are the same
	assign half = {4{mem[idx]}};
	assign dat_o.h[0] = half;
	assign dat_o.h[1] = half;

endmodule

`default_nettype wire

//--- src/io_cfg.svh
// I/O subsystem configuration
// base of the I/O window, device offsets inside it and bus widths
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// upper twelve address bits that mark a request as I/O space
`define IO_BASE 12'hFFD

// device offsets inside the 1 MB I/O window
`define IO_SCRATCH_OFS 20'h00000
`define IO_MBOX_OFS 20'h01000

// byte address widths of the two devices (32 and 16 bytes)
`define IO_SCR_AW 5
`define IO_MBX_AW 4

// CPU-side and device bus widths
`define IO_ADR_W 32
`define IO_DAT_W 64

`endif

//--- src/io_dev_decode.sv
// device decoder
// selects the device behind the current address, returns its ack and
// read data, and answers unmapped I/O addresses with all-ones data
`timescale 1ns/1ns
`default_nettype none

`include "io_cfg.svh"

module io_dev_decode
	import io_bus_pkg::*;
	import io_map_pkg::*;
(
	input  wire logic     clk_i,
	input  wire logic     rst_i,
	io_bus_if.decode      bus_d,
	output logic          scr_sel_o,
	output logic          mbx_sel_o,
	input  wire logic     scr_ack_i,
	input  wire logic     mbx_ack_i,
	input  wire io_data_u scr_dat_i,
	input  wire io_data_u mbx_dat_i
);

	localparam logic [19:0] SCR_OFS = `IO_SCRATCH_OFS;
	localparam logic [19:0] MBX_OFS = `IO_MBOX_OFS;

	io_dev_e cur_dev;
	// ack of the default responder
	logic    unm_ack;

	// upper address bits are already fixed to the base by the bridge
	always_comb begin
		if (!(bus_d.cyc && bus_d.stb))
			cur_dev = DEV_NONE;
		else if (bus_d.adr[19:`IO_SCR_AW] == SCR_OFS[19:`IO_SCR_AW])
			cur_dev = DEV_SCRATCH;
		else if (bus_d.adr[19:`IO_MBX_AW] == MBX_OFS[19:`IO_MBX_AW])
			cur_dev = DEV_MBOX;
		else
			cur_dev = DEV_UNMAPPED;
	end

	assign scr_sel_o = (cur_dev == DEV_SCRATCH);
	assign mbx_sel_o = (cur_dev == DEV_MBOX);

	// same one-edge registered ack as the real devices
	always_ff @(posedge clk_i) begin
		if (rst_i)
			unm_ack <= 1'b0;
		else
			unm_ack <= (cur_dev == DEV_UNMAPPED);
	end

	// the acks are ored so a trailing ack stays visible after stb drops
	assign bus_d.ack = scr_ack_i | mbx_ack_i | unm_ack;

	always_comb begin
		case (cur_dev)
			DEV_SCRATCH:  bus_d.dat_r = scr_dat_i;
			DEV_MBOX:     bus_d.dat_r = mbx_dat_i;
			DEV_UNMAPPED: bus_d.dat_r = '1;
			default:      bus_d.dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/io_map_pkg.sv
// I/O map types
// device select and the index types of the two devices
`default_nettype none

package io_map_pkg;

	// which responder owns the current device bus address
	typedef enum logic [1:0] {
		DEV_NONE,
		DEV_SCRATCH,
		DEV_MBOX,
		DEV_UNMAPPED
	} io_dev_e;

	// one of four 64-bit scratch registers
	typedef logic [1:0] io_reg_idx_t;

	// one of sixteen mailbox bytes
	typedef logic [3:0] io_mbox_idx_t;

endpackage

`default_nettype wire

//--- src/io_scratch_regs.sv
// scratch register bank
// four 64-bit registers, written byte by byte under the byte enables
`timescale 1ns/1ns
`default_nettype none

`include "io_cfg.svh"

module io_scratch_regs
	import io_bus_pkg::*;
	import io_map_pkg::*;
(
	input  wire logic clk_i,
	input  wire logic rst_i,
	io_bus_if.dev     bus_s,
	input  wire logic sel_i,
	output logic      ack_o,
	output io_data_u  dat_o
);

	io_data_u    regs [4];
	io_reg_idx_t idx;

	// word index from address bits 4 to 3
	assign idx = io_reg_idx_t'(bus_s.adr[`IO_SCR_AW-1:3]);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			for (int r = 0; r < 4; r++)
				regs[r] <= '0;
		end else begin
			ack_o <= sel_i & bus_s.stb;
			// only enabled lanes change, the rest of the word is kept
			if (sel_i && bus_s.stb && bus_s.we) begin
				for (int i = 0; i < $bits(io_sel_t); i++) begin
					if (bus_s.sel[i])
						regs[idx].b[i] <= bus_s.dat_w.b[i];
				end
			end
		end
	end

	// reads always return the whole word
	assign dat_o = regs[idx];

endmodule

`default_nettype wire

//--- src/io_subsystem_top.sv
// I/O subsystem top level
// two CPU-side requester ports into the bridge, then the decoder with
// the scratch bank and the byte mailbox on the device bus
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_top
	import io_bus_pkg::*;
(
	input  wire logic     clk_i,
	input  wire logic     rst_i,

	input  wire logic     s1_cyc_i,
	input  wire logic     s1_stb_i,
	input  wire logic     s1_we_i,
	input  wire io_sel_t  s1_sel_i,
	input  wire io_adr_t  s1_adr_i,
	input  wire io_data_u s1_dat_i,
	output logic          s1_ack_o,
	output io_data_u      s1_dat_o,

	input  wire logic     s2_cyc_i,
	input  wire logic     s2_stb_i,
	input  wire logic     s2_we_i,
	input  wire io_sel_t  s2_sel_i,
	input  wire io_adr_t  s2_adr_i,
	input  wire io_data_u s2_dat_i,
	output logic          s2_ack_o,
	output io_data_u      s2_dat_o
);

	// per-device select, ack and read data back to the decoder
	logic     scr_sel;
	logic     mbx_sel;
	logic     scr_ack;
	logic     mbx_ack;
	io_data_u scr_dat;
	io_data_u mbx_dat;

	io_bus_if u_bus ();

	io_bridge u_bridge (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.s1_cyc_i (s1_cyc_i),
		.s1_stb_i (s1_stb_i),
		.s1_we_i  (s1_we_i),
		.s1_sel_i (s1_sel_i),
		.s1_adr_i (s1_adr_i),
		.s1_dat_i (s1_dat_i),
		.s1_ack_o (s1_ack_o),
		.s1_dat_o (s1_dat_o),
		.s2_cyc_i (s2_cyc_i),
		.s2_stb_i (s2_stb_i),
		.s2_we_i  (s2_we_i),
		.s2_sel_i (s2_sel_i),
		.s2_adr_i (s2_adr_i),
		.s2_dat_i (s2_dat_i),
		.s2_ack_o (s2_ack_o),
		.s2_dat_o (s2_dat_o),
		.bus_m    (u_bus.master)
	);

	io_dev_decode u_decode (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.bus_d     (u_bus.decode),
		.scr_sel_o (scr_sel),
		.mbx_sel_o (mbx_sel),
		.scr_ack_i (scr_ack),
		.mbx_ack_i (mbx_ack),
		.scr_dat_i (scr_dat),
		.mbx_dat_i (mbx_dat)
	);

	io_scratch_regs u_scratch (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus_s (u_bus.dev),
		.sel_i (scr_sel),
		.ack_o (scr_ack),
		.dat_o (scr_dat)
	);

	io_byte_mailbox u_mailbox (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus_s (u_bus.dev),
		.sel_i (mbx_sel),
		.ack_o (mbx_ack),
		.dat_o (mbx_dat)
	);

endmodule

`default_nettype wire

//--- testbench/tb_io_subsystem.sv
// testbench for the I/O subsystem
// drives both requester ports, keeps a shadow model of the scratch bank
// and the mailbox, and checks read data and ack timing with assertions
`timescale 1ns/1ns
`default_nettype none

`include "io_cfg.svh"

module tb_io_subsystem
	import io_bus_pkg::*;
();

	// the tests need well under 800 cycles, this is about four times that
	localparam int MAX_CYCLES = 3000;

	logic     clk_i;
	logic     rst_i;
	logic     s1_cyc, s1_stb, s1_we, s1_ack;
	logic     s2_cyc, s2_stb, s2_we, s2_ack;
	io_sel_t  s1_sel, s2_sel;
	io_adr_t  s1_adr, s2_adr;
	io_data_u s1_dat, s2_dat, s1_rdat, s2_rdat;
	// high for the one edge that samples a request on an idle bridge
	logic     s1_start, s2_start;

	logic [63:0] scr_model [4];
	logic [7:0]  mbx_model [16];
	int          seed;
	int          cycles;
	int          checks;
	int          errors;

	io_subsystem_top u_dut (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.s1_cyc_i (s1_cyc),
		.s1_stb_i (s1_stb),
		.s1_we_i  (s1_we),
		.s1_sel_i (s1_sel),
		.s1_adr_i (s1_adr),
		.s1_dat_i (s1_dat),
		.s1_ack_o (s1_ack),
		.s1_dat_o (s1_rdat),
		.s2_cyc_i (s2_cyc),
		.s2_stb_i (s2_stb),
		.s2_we_i  (s2_we),
		.s2_sel_i (s2_sel),
		.s2_adr_i (s2_adr),
		.s2_dat_i (s2_dat),
		.s2_ack_o (s2_ack),
		.s2_dat_o (s2_rdat)
	);

	always #20 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("ERROR: timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ============================================================
	// ack timing properties
	// ============================================================

	// acks stay low while reset is held and on the edge after it
	a_reset_ack: assert property (@(posedge clk_i) rst_i |=> (!s1_ack && !s2_ack))
		else begin
			errors++;
			$display("ERROR: a port ack was high during or right after reset");
		end

	// the port ack rises on the fourth edge after the sampling edge,
	// which shows up one edge later in the sampled values
	a_s1_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		s1_start |-> ##5 $rose(s1_ack))
		else begin
			errors++;
			$display("ERROR: port 1 ack did not rise 4 edges after its request was sampled");
		end
	a_s2_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		s2_start |-> ##5 $rose(s2_ack))
		else begin
			errors++;
			$display("ERROR: port 2 ack did not rise 4 edges after its request was sampled");
		end

	// once the requester lets go of stb the ack falls on the next edge
	a_s1_release: assert property (@(posedge clk_i) disable iff (rst_i)
		(s1_ack && !s1_stb) |=> !s1_ack)
		else begin
			errors++;
			$display("ERROR: port 1 ack stayed high after stb was dropped");
		end
	a_s2_release: assert property (@(posedge clk_i) disable iff (rst_i)
		(s2_ack && !s2_stb) |=> !s2_ack)
		else begin
			errors++;
			$display("ERROR: port 2 ack stayed high after stb was dropped");
		end

	// only one transfer runs at a time, so only one port is acknowledged
	a_one_owner: assert property (@(posedge clk_i) disable iff (rst_i) !(s1_ack && s2_ack))
		else begin
			errors++;
			$display("ERROR: both ports were acknowledged in the same cycle");
		end

	// ============================================================
	// helpers
	// ============================================================

	function automatic io_adr_t scr_adr(input int idx);
		return {`IO_BASE, `IO_SCRATCH_OFS + 20'(idx * 8)};
	endfunction

	function automatic io_adr_t mbx_adr(input int a);
		return {`IO_BASE, `IO_MBOX_OFS + 20'(a)};
	endfunction

	// a single enabled lane puts the mailbox byte on the steered lane
	function automatic io_sel_t lane_sel(input int a);
		return io_sel_t'(1 << (a % 8));
	endfunction

	// shadow of a scratch write, only enabled bytes take the new value
	function automatic logic [63:0] merge_bytes(input logic [63:0] old,
			input logic [63:0] wd, input io_sel_t sel);
		logic [63:0] res;
		res = old;
		for (int i = 0; i < 8; i++) begin
			if (sel[i])
				res[8*i +: 8] = wd[8*i +: 8];
		end
		return res;
	endfunction

	task automatic check_cond(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR: %s", msg);
		end
	endtask

	task automatic check_word(input string name, input io_adr_t adr,
			input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR: %s at adr %h got %h expected %h", name, adr, got, exp);
		end
	endtask

	task automatic drive_port(input int port, input logic act, input logic we,
			input io_sel_t sel, input io_adr_t adr, input io_data_u dat);
		if (port == 1) begin
			s1_cyc = act;
			s1_stb = act;
			s1_we  = we;
			s1_sel = sel;
			s1_adr = adr;
			s1_dat = dat;
		end else begin
			s2_cyc = act;
			s2_stb = act;
			s2_we  = we;
			s2_sel = sel;
			s2_adr = adr;
			s2_dat = dat;
		end
	endtask

	// one transfer on one port, called on a falling edge; the request is
	// held until the ack is seen or the limit runs out, then released
	task automatic bus_xfer(input int port, input logic we, input io_sel_t sel,
			input io_adr_t adr, input io_data_u wdat, input logic timed,
			input int limit, output io_data_u rdat, output logic acked,
			output int ack_cyc);
		int waited;
		waited = 0;
		acked = 1'b0;
		rdat = '0;
		drive_port(port, 1'b1, we, sel, adr, wdat);
		if (port == 1)
			s1_start = timed;
		else
			s2_start = timed;
		while (!acked && waited < limit) begin
			@(negedge clk_i);
			waited++;
			if (port == 1) begin
				s1_start = 1'b0;
				acked = s1_ack;
				rdat = s1_rdat;
			end else begin
				s2_start = 1'b0;
				acked = s2_ack;
				rdat = s2_rdat;
			end
		end
		ack_cyc = cycles;
		drive_port(port, 1'b0, 1'b0, '0, '0, '0);
		// lets the trailing device ack clear so the bridge is idle again
		repeat (2) @(negedge clk_i);
	endtask

	task automatic write_check(input int port, input io_sel_t sel, input io_adr_t adr,
			input logic [63:0] dat);
		io_data_u rd;
		logic     ok;
		int       cy;
		bus_xfer(port, 1'b1, sel, adr, dat, 1'b1, 16, rd, ok, cy);
		check_cond(ok, $sformatf("write to %h on port %0d was not acknowledged", adr, port));
	endtask

	task automatic read_check(input int port, input io_sel_t sel, input io_adr_t adr,
			input logic [63:0] exp);
		io_data_u rd;
		logic     ok;
		int       cy;
		bus_xfer(port, 1'b0, sel, adr, '0, 1'b1, 16, rd, ok, cy);
		check_cond(ok, $sformatf("read of %h on port %0d was not acknowledged", adr, port));
		if (ok)
			check_word($sformatf("s%0d_dat_o", port), adr, rd, exp);
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		logic [63:0] wd;
		io_sel_t     sel;
		int          idx;
		io_data_u    rd1, rd2;
		logic        ok1, ok2;
		int          cy1, cy2;

		seed = 38570;
		cycles = 0;
		checks = 0;
		errors = 0;
		clk_i = 1'b0;
		rst_i = 1'b1;
		s1_start = 1'b0;
		s2_start = 1'b0;
		drive_port(1, 1'b0, 1'b0, '0, '0, '0);
		drive_port(2, 1'b0, 1'b0, '0, '0, '0);
		for (int r = 0; r < 4; r++)
			scr_model[r] = '0;
		for (int a = 0; a < 16; a++)
			mbx_model[a] = '0;
		repeat (2) @(negedge clk_i);
		rst_i = 1'b0;
		check_cond(!s1_ack && !s2_ack, "a port ack was high right after reset");

		// all storage reads back as zero after reset
		for (int r = 0; r < 4; r++)
			read_check(1, 8'hff, scr_adr(r), 64'h0);
		for (int a = 0; a < 16; a++)
			read_check(2, lane_sel(a), mbx_adr(a), 64'h0);

		// scratch bank, random byte-enable writes and read-back on the other port
		for (int n = 0; n < 16; n++) begin
			idx = $random(seed) & 3;
			wd = {$random(seed), $random(seed)};
			sel = io_sel_t'($random(seed));
			scr_model[idx] = merge_bytes(scr_model[idx], wd, sel);
			write_check(1, sel, scr_adr(idx), wd);
			read_check(2, 8'hff, scr_adr(idx), scr_model[idx]);
		end

		// mailbox, one byte per lane position with noise on the other lanes
		for (int a = 0; a < 16; a++) begin
			wd = {$random(seed), $random(seed)};
			mbx_model[a] = wd[8*(a%8) +: 8];
			write_check(2, lane_sel(a), mbx_adr(a), wd);
		end
		for (int a = 0; a < 16; a++)
			read_check(1, lane_sel(a), mbx_adr(a), {8{mbx_model[a]}});

		// requests outside the I/O window must be ignored entirely
		bus_xfer(1, 1'b1, 8'hff, {`IO_BASE ^ 12'h001, 20'h00008}, '1, 1'b0, 8, rd1, ok1, cy1);
		check_cond(!ok1, "an out-of-range scratch write was acknowledged");
		bus_xfer(2, 1'b1, lane_sel(3), {`IO_BASE ^ 12'h800, `IO_MBOX_OFS + 20'h3}, '1,
			1'b0, 8, rd2, ok2, cy2);
		check_cond(!ok2, "an out-of-range mailbox write was acknowledged");
		for (int r = 0; r < 4; r++)
			read_check(2, 8'hff, scr_adr(r), scr_model[r]);
		read_check(1, lane_sel(3), mbx_adr(3), {8{mbx_model[3]}});

		// holes in the I/O map are answered by the default responder
		read_check(1, 8'hff, {`IO_BASE, 20'h02000}, '1);
		read_check(2, 8'hff, {`IO_BASE, 20'h00020}, '1);

		// same-cycle requests, port 1 writes first so port 2 reads the new word
		wd = {$random(seed), $random(seed)};
		scr_model[3] = wd;
		fork
			bus_xfer(1, 1'b1, 8'hff, scr_adr(3), wd, 1'b1, 16, rd1, ok1, cy1);
			bus_xfer(2, 1'b0, 8'hff, scr_adr(3), '0, 1'b0, 16, rd2, ok2, cy2);
		join
		check_cond(ok1 && ok2, "a transfer of the same-cycle pair was not acknowledged");
		check_cond(cy1 < cy2, "port 2 was acknowledged before port 1");
		check_word("s2_dat_o", scr_adr(3), rd2, scr_model[3]);

		// second pair with a mailbox read against a mailbox write
		wd = {$random(seed), $random(seed)};
		mbx_model[12] = wd[39:32];
		fork
			bus_xfer(1, 1'b0, lane_sel(5), mbx_adr(5), '0, 1'b1, 16, rd1, ok1, cy1);
			bus_xfer(2, 1'b1, lane_sel(12), mbx_adr(12), wd, 1'b0, 16, rd2, ok2, cy2);
		join
		check_cond(ok1 && ok2, "a transfer of the same-cycle pair was not acknowledged");
		check_cond(cy1 < cy2, "port 2 was acknowledged before port 1");
		check_word("s1_dat_o", mbx_adr(5), rd1, {8{mbx_model[5]}});
		read_check(1, lane_sel(12), mbx_adr(12), {8{mbx_model[12]}});

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
